// File: vlog.f
common/mpu_pkg.sv
mpu/mpu_host_if.sv
mpu/mpu_thread_mem.sv
mpu/mpu_map_table.sv
mpu/mpu_issue_commit.sv
mpu/mpu_dispatch.sv
verilog/mpu_top.sv
test/mpu_checker.sv
test/tb_mpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the MPU testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_mpu \
	-f vlog.f \
	--Mdir obj_dir \
	-o tb_mpu_sim

./obj_dir/tb_mpu_sim | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: test/tb_mpu.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// MPU testbench top
// Host command driver, array ready and commit, timeout
////////////////////////////////////////////////////////////
module tb_mpu;
	import mpu_pkg::*;

	localparam int SIZE_THREAD_MEM = 64;
	localparam int NUM_ISSUE       = 4;

	logic      clock = 1'b0;
	logic      reset;
	logic      host_req;
	host_cmd_t host_cmd;
	logic      host_ack;
	host_rsp_t host_rsp;
	logic      tpu_valid;
	tpu_beat_t tpu_beat;
	logic      tpu_ready;
	logic      commit_req;
	issue_no_t commit_no;
	mpu_stat_t status;
	int        err_count;                   // From the checker
	int        beat_count;
	int        pending;
	int        tb_errors;
	int        errors_seen;
	integer    seed;
	integer    ready_seed;
	logic      ready_random;
	int        cycles = 0;
	int        cycle_limit;
	int        thread_len [NUM_THREADS];
	int        len_sum;
	int        cmd_words;
	int        total;
	issue_no_t next_no;
	issue_no_t flight_q [$];                // Issue numbers not yet committed

	always #4 clock = ~clock;

	mpu_top #(
		.SIZE_THREAD_MEM (SIZE_THREAD_MEM),
		.NUM_ISSUE       (NUM_ISSUE)
	) i_dut (
		.clock      (clock),
		.reset      (reset),
		.host_req   (host_req),
		.host_cmd   (host_cmd),
		.host_ack   (host_ack),
		.host_rsp   (host_rsp),
		.tpu_valid  (tpu_valid),
		.tpu_beat   (tpu_beat),
		.tpu_ready  (tpu_ready),
		.commit_req (commit_req),
		.commit_no  (commit_no),
		.status     (status)
	);

	mpu_checker #(
		.SIZE_THREAD_MEM (SIZE_THREAD_MEM)
	) i_checker (
		.clock      (clock),
		.reset      (reset),
		.host_cmd   (host_cmd),
		.host_ack   (host_ack),
		.host_rsp   (host_rsp),
		.tpu_valid  (tpu_valid),
		.tpu_beat   (tpu_beat),
		.tpu_ready  (tpu_ready),
		.status     (status),
		.err_count  (err_count),
		.beat_count (beat_count),
		.pending    (pending)
	);

	// Array back-pressure
	initial begin
		tpu_ready = 1'b1;
		forever begin
			@(posedge clock);
			#1;
			tpu_ready = ready_random ? 1'($random(ready_seed)) : 1'b1;
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, %0d runs still streaming", cycles, pending);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Host and array tasks
	////////////////////////////////////////////////////////////
	task automatic tick();
		@(posedge clock);
		#1;
	endtask

	function automatic host_cmd_t make_cmd(host_op_t op, id_t id, int len, instr_t instr);
		host_cmd_t c;
		c.op        = op;
		c.thread_id = id;
		c.length    = length_t'(len);
		c.instr     = instr;
		return c;
	endfunction

	// Four-phase exchange, ends with ack low again
	task automatic host_send(input host_cmd_t cmd, output logic ok);
		host_cmd = cmd;
		host_req = 1'b1;
		tick();
		while (!host_ack) begin
			tick();
		end
		ok       = host_rsp.ok;
		host_req = 1'b0;
		while (host_ack) begin
			tick();
		end
	endtask

	task automatic load_thread(input id_t id, input int len);
		logic ok;
		host_send(make_cmd(op_define, id, len, '0), ok);
		for (int i = 0; i < len; i++) begin
			host_send(make_cmd(op_write, id, 0, $random(seed)), ok);
		end
	endtask

	task automatic run_thread(input id_t id);
		logic ok;
		host_send(make_cmd(op_run, id, 0, '0), ok);
		if (ok) begin
			flight_q.push_back(next_no);
			next_no = next_no + 3'd1;
		end
	endtask

	task automatic commit_issue(input issue_no_t no);
		commit_req = 1'b1;
		commit_no  = no;
		tick();
		commit_req = 1'b0;
	endtask

	task automatic commit_random();
		int idx;
		idx = int'($unsigned($random(seed)) % 32'(flight_q.size()));
		commit_issue(flight_q[idx]);
		flight_q.delete(idx);
	endtask

	task automatic commit_all();
		while (flight_q.size() != 0) begin
			commit_random();
		end
	endtask

	task automatic wait_streams();
		while (pending != 0) begin
			tick();
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			tb_errors++;
		end
	endtask

	task automatic report_test(input int num, input string name);
		int sum;
		sum = err_count + tb_errors;
		$display("Test %0d %s: %0d errors", num, name, sum - errors_seen);
		errors_seen = sum;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial begin
		seed         = 32'hf7081503;
		ready_seed   = seed;
		reset        = 1'b1;
		host_req     = 1'b0;
		host_cmd     = '0;
		commit_req   = 1'b0;
		commit_no    = '0;
		ready_random = 1'b0;
		tb_errors    = 0;
		errors_seen  = 0;
		next_no      = '0;
		cycle_limit  = 0;
		for (int i = 0; i < 3; i++) begin
			thread_len[id_t'(i)] = 8 + int'($unsigned($random(seed)) % 32'd12);
		end
		len_sum       = thread_len[0] + thread_len[1] + thread_len[2];
		thread_len[3] = SIZE_THREAD_MEM - len_sum;     // Fills the memory exactly
		cmd_words     = 3 + len_sum + 3 + 3 + (2 * thread_len[3] + 6) + 5 + 3;
		// Tests 4 and 5 stream each of threads 0 to 3 twice
		cycle_limit   = 20 * (cmd_words + 2 * len_sum + 2 * SIZE_THREAD_MEM) + 2000;

		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		tick();
		check_value("host_ack", 32'(host_ack), 0);
		check_value("tpu_valid", 32'(tpu_valid), 0);
		check_value("status", 32'(status), 0);

		for (int i = 0; i < 3; i++) begin
			load_thread(id_t'(i), thread_len[id_t'(i)]);
		end
		for (int i = 0; i < 3; i++) begin
			run_thread(id_t'(i));
		end
		wait_streams();
		commit_all();
		report_test(1, "streams with ready high");

		ready_random = 1'b1;
		for (int i = 0; i < 3; i++) begin
			run_thread(id_t'(i));
		end
		wait_streams();
		ready_random = 1'b0;
		commit_all();
		report_test(2, "streams with random ready");

		load_thread(3'd3, thread_len[3] + 1);          // Beyond remaining space
		load_thread(3'd0, 1);                          // Already defined
		run_thread(3'd5);                              // Never defined
		load_thread(3'd3, thread_len[3]);
		check_value("status.mem_full", 32'(status.mem_full), 1);
		report_test(3, "refused commands and full memory");

		for (int k = 0; k < NUM_ISSUE; k++) begin
			run_thread(id_t'(k % 4));
		end
		check_value("status.commit_full", 32'(status.commit_full), 1);
		fork
			run_thread(3'd0);
			begin
				repeat (40) begin
					tick();
					if (host_ack) begin
						$display("Run acknowledged while all issue slots were in flight");
						tb_errors++;
					end
				end
				commit_issue(flight_q.pop_front());
			end
		join
		report_test(4, "run held while slots are full");

		for (int k = 5; k < 8; k++) begin
			fork
				run_thread(id_t'(k % 4));
				begin
					repeat (8) tick();
					commit_random();
				end
			join
		end
		wait_streams();
		commit_all();
		check_value("status.commit_full", 32'(status.commit_full), 0);
		check_value("status.sending", 32'(status.sending), 0);
		report_test(5, "out of order commits");

		total = err_count + tb_errors;
		$display("Tests 5, beats %0d, errors %0d", beat_count, total);
		if (total == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: test/mpu_checker.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// MPU testbench checker
// Reference model of map and memory, host and stream checks
////////////////////////////////////////////////////////////
module mpu_checker #(
	parameter int SIZE_THREAD_MEM = mpu_pkg::SIZE_THREAD_MEM_DEF
) (
	input  logic               clock,
	input  logic               reset,
	input  mpu_pkg::host_cmd_t host_cmd,
	input  logic               host_ack,
	input  mpu_pkg::host_rsp_t host_rsp,
	input  logic               tpu_valid,
	input  mpu_pkg::tpu_beat_t tpu_beat,
	input  logic               tpu_ready,
	input  mpu_pkg::mpu_stat_t status,
	output int                 err_count,
	output int                 beat_count,
	output int                 pending
);
	import mpu_pkg::*;

	logic      ref_valid [NUM_THREADS];
	int        ref_base  [NUM_THREADS];
	int        ref_len   [NUM_THREADS];
	instr_t    ref_mem   [SIZE_THREAD_MEM];
	int        used;                        // Words handed out so far
	logic      open_ok;                     // Last define accepted
	int        open_base;
	int        open_len;
	int        open_cnt;
	issue_no_t next_issue;
	logic      ack_seen;
	id_t       run_id_q [$];                // Runs waiting for their stream
	issue_no_t run_no_q [$];
	int        beat_idx;

	// Expected beat for word idx of a thread under a given issue number
	function automatic tpu_beat_t expected_beat(id_t id, int idx, issue_no_t no);
		tpu_beat_t b;
		b.instr    = ref_mem[t_address_t'(ref_base[id] + idx)];
		b.issue_no = no;
		b.last     = (idx == ref_len[id] - 1);
		return b;
	endfunction

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			err_count++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Host command model
	////////////////////////////////////////////////////////////
	task automatic apply_command();
		logic accept;
		logic all_valid;
		int   len;
		id_t  id;
		id  = host_cmd.thread_id;
		len = int'(host_cmd.length);
		case (host_cmd.op)
			op_define: begin
				accept = !ref_valid[id] && (len != 0) && (used + len <= SIZE_THREAD_MEM);
				check_bit("host_rsp.ok", host_rsp.ok, accept);
				open_ok   = accept;
				open_base = used;
				open_len  = len;
				open_cnt  = 0;
				if (accept) begin
					ref_valid[id] = 1'b1;
					ref_base[id]  = used;
					ref_len[id]   = len;
					used          = used + len;
				end
				all_valid = 1'b1;
				for (int i = 0; i < NUM_THREADS; i++) begin
					all_valid = all_valid & ref_valid[id_t'(i)];
				end
				check_bit("status.mem_full", status.mem_full, used == SIZE_THREAD_MEM);
				check_bit("status.map_full", status.map_full, all_valid);
			end
			op_write: begin
				accept = open_ok && (open_cnt < open_len);
				check_bit("host_rsp.ok", host_rsp.ok, accept);
				if (accept) begin
					ref_mem[t_address_t'(open_base + open_cnt)] = host_cmd.instr;
					open_cnt++;
				end
			end
			op_run: begin
				accept = ref_valid[id];
				check_bit("host_rsp.ok", host_rsp.ok, accept);
				if (accept) begin
					run_id_q.push_back(id);
					run_no_q.push_back(next_issue);
					next_issue = next_issue + 3'd1;     // Wraps at 8
				end
			end
			default: check_bit("host_rsp.ok", host_rsp.ok, 1'b0);
		endcase
	endtask

	task automatic check_beat();
		tpu_beat_t exp;
		if (run_id_q.size() == 0) begin
			$display("Beat transferred to the array with no run pending");
			err_count++;
		end else begin
			exp = expected_beat(run_id_q[0], beat_idx, run_no_q[0]);
			if (tpu_beat !== exp) begin
				$display("Mismatch tpu_beat: got instr %h issue_no %h last %h, expected %h %h %h",
					tpu_beat.instr, tpu_beat.issue_no, tpu_beat.last,
					exp.instr, exp.issue_no, exp.last);
				err_count++;
			end
			beat_idx++;
			if (beat_idx == ref_len[run_id_q[0]]) begin   // Stream complete
				void'(run_id_q.pop_front());
				void'(run_no_q.pop_front());
				beat_idx = 0;
			end
		end
		beat_count++;
	endtask

	// Sampled on the falling edge, where all ports are settled
	always @(negedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_THREADS; i++) begin
				ref_valid[id_t'(i)] = 1'b0;
			end
			used       = 0;
			open_ok    = 1'b0;
			next_issue = '0;
			ack_seen   = 1'b0;
			beat_idx   = 0;
			err_count  = 0;
			beat_count = 0;
			run_id_q.delete();
			run_no_q.delete();
		end else begin
			if (host_ack && !ack_seen) begin
				apply_command();
			end
			ack_seen = host_ack;
			if (tpu_valid && tpu_ready) begin
				check_beat();
			end
		end
		pending = run_id_q.size();
	end

endmodule

// File: verilog/mpu_top.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// MPU top level
// Host port, thread store, map, issue tracking, dispatch
////////////////////////////////////////////////////////////
module mpu_top #(
	parameter int SIZE_THREAD_MEM = mpu_pkg::SIZE_THREAD_MEM_DEF,
	parameter int NUM_ISSUE       = mpu_pkg::NUM_ISSUE_DEF
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               host_req,
	input  mpu_pkg::host_cmd_t host_cmd,
	output logic               host_ack,
	output mpu_pkg::host_rsp_t host_rsp,
	output logic               tpu_valid,
	output mpu_pkg::tpu_beat_t tpu_beat,
	input  logic               tpu_ready,
	input  logic               commit_req,
	input  mpu_pkg::issue_no_t commit_no,
	output mpu_pkg::mpu_stat_t status
);
	import mpu_pkg::*;

	logic       map_def_req;
	logic       map_def_done;
	logic       map_def_ok;
	t_address_t map_def_base;
	id_t        query_id;
	map_entry_t query_entry;
	id_t        lookup_id;
	map_entry_t lookup_entry;
	logic       mem_we;
	t_address_t mem_waddr;
	instr_t     mem_wdata;
	t_address_t mem_raddr;
	instr_t     mem_rdata;
	logic       issue_req;
	logic       issue_done;
	logic       disp_req;
	id_t        disp_id;
	issue_no_t  disp_issue_no;
	logic       disp_taken;
	logic       host_busy;
	logic       mem_full;
	logic       map_full;
	logic       commit_full;
	logic       sending;

	assign status = '{busy: host_busy, mem_full: mem_full, map_full: map_full,
		commit_full: commit_full, sending: sending};

	////////////////////////////////////////////////////////////
	// Block instances
	////////////////////////////////////////////////////////////
	mpu_host_if i_host_if (
		.clock        (clock),
		.reset        (reset),
		.host_req     (host_req),
		.host_cmd     (host_cmd),
		.host_ack     (host_ack),
		.host_rsp     (host_rsp),
		.map_def_req  (map_def_req),
		.map_def_done (map_def_done),
		.map_def_ok   (map_def_ok),
		.map_def_base (map_def_base),
		.map_entry    (query_entry),
		.map_query_id (query_id),
		.mem_we       (mem_we),
		.mem_waddr    (mem_waddr),
		.mem_wdata    (mem_wdata),
		.issue_req    (issue_req),
		.issue_done   (issue_done),
		.busy         (host_busy)
	);

	mpu_thread_mem i_thread_mem (
		.clock (clock),
		.we    (mem_we),
		.waddr (mem_waddr),
		.wdata (mem_wdata),
		.raddr (mem_raddr),
		.rdata (mem_rdata)
	);

	// Define takes its id from the query path, length from the command
	mpu_map_table #(
		.SIZE_THREAD_MEM (SIZE_THREAD_MEM)
	) i_map_table (
		.clock        (clock),
		.reset        (reset),
		.def_req      (map_def_req),
		.def_id       (query_id),
		.def_len      (host_cmd.length),
		.def_done     (map_def_done),
		.def_ok       (map_def_ok),
		.def_base     (map_def_base),
		.query_id     (query_id),
		.query_entry  (query_entry),
		.lookup_id    (lookup_id),
		.lookup_entry (lookup_entry),
		.mem_full     (mem_full),
		.map_full     (map_full)
	);

	mpu_issue_commit #(
		.NUM_ISSUE (NUM_ISSUE)
	) i_issue_commit (
		.clock         (clock),
		.reset         (reset),
		.issue_req     (issue_req),
		.issue_id      (query_id),
		.issue_done    (issue_done),
		.disp_req      (disp_req),
		.disp_id       (disp_id),
		.disp_issue_no (disp_issue_no),
		.disp_taken    (disp_taken),
		.commit_req    (commit_req),
		.commit_no     (commit_no),
		.commit_full   (commit_full)
	);

	mpu_dispatch i_dispatch (
		.clock         (clock),
		.reset         (reset),
		.disp_req      (disp_req),
		.disp_id       (disp_id),
		.disp_issue_no (disp_issue_no),
		.disp_taken    (disp_taken),
		.lookup_id     (lookup_id),
		.lookup_entry  (lookup_entry),
		.mem_raddr     (mem_raddr),
		.mem_rdata     (mem_rdata),
		.tpu_valid     (tpu_valid),
		.tpu_beat      (tpu_beat),
		.tpu_ready     (tpu_ready),
		.sending       (sending)
	);

endmodule

// File: mpu/mpu_dispatch.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// MPU dispatch
// Streams thread words to the array under back-pressure
////////////////////////////////////////////////////////////
module mpu_dispatch (
	input  logic                clock,
	input  logic                reset,
	input  logic                disp_req,
	input  mpu_pkg::id_t        disp_id,
	input  mpu_pkg::issue_no_t  disp_issue_no,
	output logic                disp_taken,
	output mpu_pkg::id_t        lookup_id,
	input  mpu_pkg::map_entry_t lookup_entry,
	output mpu_pkg::t_address_t mem_raddr,
	input  mpu_pkg::instr_t     mem_rdata,
	output logic                tpu_valid,
	output mpu_pkg::tpu_beat_t  tpu_beat,
	input  logic                tpu_ready,
	output logic                sending
);
	import mpu_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_lookup,
		st_read,
		st_stream
	} state_t;

	state_t     state;
	id_t        cur_id;
	issue_no_t  cur_no;
	t_address_t base;
	length_t    len;
	length_t    rd_idx;                     // Word now in mem_rdata
	length_t    rd_next;
	logic       load;
	logic       xfer;

	assign xfer      = tpu_valid && tpu_ready;
	assign load      = (state == st_stream) && (rd_idx < len) && (!tpu_valid || tpu_ready);
	assign rd_next   = load ? rd_idx + 7'd1 : rd_idx;
	assign mem_raddr = base + rd_next[5:0];     // Next read issued with the load
	assign lookup_id = cur_id;
	assign sending   = (state != st_idle);

	////////////////////////////////////////////////////////////
	// Stream control
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= st_idle;
			disp_taken <= 1'b0;
			tpu_valid  <= 1'b0;
			rd_idx     <= '0;
		end else begin
			disp_taken <= 1'b0;
			case (state)
				st_idle: begin
					if (disp_req) begin
						disp_taken <= 1'b1;     // Empties the hand-off register
						rd_idx     <= '0;
						state      <= st_lookup;
					end
				end
				st_lookup: state <= st_read;
				st_read:   state <= st_stream;  // First word read in flight
				st_stream: begin
					if (load) begin
						tpu_valid <= 1'b1;
						rd_idx    <= rd_idx + 7'd1;
					end else if (xfer) begin
						tpu_valid <= 1'b0;
					end
					if (xfer && tpu_beat.last) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Thread context and output beat
	always_ff @(posedge clock) begin
		if (state == st_idle && disp_req) begin
			cur_id <= disp_id;
			cur_no <= disp_issue_no;
		end
		if (state == st_lookup) begin
			base <= lookup_entry.base;
			len  <= lookup_entry.length;
		end
		if (load) begin
			tpu_beat <= '{instr: mem_rdata, issue_no: cur_no, last: (rd_idx == len - 7'd1)};
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		tpu_valid && !tpu_ready |=> tpu_valid && $stable(tpu_beat))
		else $error("tpu_beat dropped or changed under back-pressure");

endmodule

// File: mpu/mpu_issue_commit.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// MPU issue and commit tracking
// Hands out issue numbers and frees them on commit
////////////////////////////////////////////////////////////
module mpu_issue_commit #(
	parameter int NUM_ISSUE = mpu_pkg::NUM_ISSUE_DEF
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               issue_req,
	input  mpu_pkg::id_t       issue_id,
	output logic               issue_done,
	output logic               disp_req,
	output mpu_pkg::id_t       disp_id,
	output mpu_pkg::issue_no_t disp_issue_no,
	input  logic               disp_taken,
	input  logic               commit_req,
	input  mpu_pkg::issue_no_t commit_no,
	output logic               commit_full
);
	import mpu_pkg::*;

	localparam int NUM_NO = 1 << $bits(issue_no_t);

	issue_no_t         next_no;
	logic [NUM_NO-1:0] in_flight;               // One bit per issue number
	logic [3:0]        flight_cnt;
	logic              can_issue;
	logic              issue_go;

	assign flight_cnt  = 4'($countones(in_flight));
	assign commit_full = (flight_cnt == 4'(NUM_ISSUE));

	// Slot free, hand-off empty, number not still outstanding
	assign can_issue = (flight_cnt < 4'(NUM_ISSUE)) && !disp_req && !in_flight[next_no];
	assign issue_go  = issue_req && !issue_done && can_issue;

	////////////////////////////////////////////////////////////
	// Slot tracking and hand-off control
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			next_no    <= '0;
			in_flight  <= '0;
			issue_done <= 1'b0;
			disp_req   <= 1'b0;
		end else begin
			issue_done <= 1'b0;
			if (commit_req) begin
				in_flight[commit_no] <= 1'b0;    // Freed next cycle
			end
			if (disp_taken) begin
				disp_req <= 1'b0;
			end
			if (issue_go) begin
				issue_done         <= 1'b1;
				disp_req           <= 1'b1;
				in_flight[next_no] <= 1'b1;
				next_no            <= next_no + 3'd1;
			end
		end
	end

	// Hand-off register contents
	always_ff @(posedge clock) begin
		if (issue_go) begin
			disp_id       <= issue_id;
			disp_issue_no <= next_no;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		commit_req |-> in_flight[commit_no])
		else $error("Commit of an issue number not in flight");

endmodule

// File: mpu/mpu_map_table.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// MPU map table
// Per-thread base and length, in-order space allocation
////////////////////////////////////////////////////////////
module mpu_map_table #(
	parameter int SIZE_THREAD_MEM = mpu_pkg::SIZE_THREAD_MEM_DEF
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                def_req,
	input  mpu_pkg::id_t        def_id,
	input  mpu_pkg::length_t    def_len,
	output logic                def_done,
	output logic                def_ok,
	output mpu_pkg::t_address_t def_base,
	input  mpu_pkg::id_t        query_id,
	output mpu_pkg::map_entry_t query_entry,
	input  mpu_pkg::id_t        lookup_id,
	output mpu_pkg::map_entry_t lookup_entry,
	output logic                mem_full,
	output logic                map_full
);
	import mpu_pkg::*;

	map_entry_t             map_q [NUM_THREADS];
	length_t                used_size;      // Allocation pointer
	logic [7:0]             need_size;
	logic                   def_accept;
	logic [NUM_THREADS-1:0] valid_bits;

	assign need_size  = {1'b0, used_size} + {1'b0, def_len};
	assign def_accept = !map_q[def_id].valid && (def_len != '0) &&
		(need_size <= 8'(SIZE_THREAD_MEM));

	always_comb begin
		for (int i = 0; i < NUM_THREADS; i++) begin
			valid_bits[i] = map_q[i].valid;
		end
	end

	assign query_entry  = map_q[query_id];
	assign lookup_entry = map_q[lookup_id];
	assign mem_full     = (used_size == length_t'(SIZE_THREAD_MEM));
	assign map_full     = &valid_bits;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_THREADS; i++) begin
				map_q[i] <= '0;
			end
			used_size <= '0;
			def_done  <= 1'b0;
			def_ok    <= 1'b0;
			def_base  <= '0;
		end else begin
			def_done <= 1'b0;                   // Single cycle pulse
			if (def_req && !def_done) begin
				def_done <= 1'b1;
				def_ok   <= def_accept;
				def_base <= used_size[5:0];
				if (def_accept) begin
					map_q[def_id] <= '{valid: 1'b1, base: used_size[5:0], length: def_len};
					used_size     <= used_size + def_len;
				end
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		int'(used_size) <= SIZE_THREAD_MEM)
		else $error("Thread memory overallocated");

endmodule

// File: mpu/mpu_thread_mem.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// MPU thread memory
// Instruction store, host write port, registered read port
////////////////////////////////////////////////////////////
module mpu_thread_mem (
	input  logic                clock,
	input  logic                we,
	input  mpu_pkg::t_address_t waddr,
	input  mpu_pkg::instr_t     wdata,
	input  mpu_pkg::t_address_t raddr,
	output mpu_pkg::instr_t     rdata
);
	import mpu_pkg::*;

	localparam int DEPTH = 1 << $bits(t_address_t);

	instr_t mem [DEPTH];

	always_ff @(posedge clock) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];                    // One cycle latency
	end

endmodule

// File: mpu/mpu_host_if.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// MPU host interface
// Four-phase command port, decodes define, write and run
////////////////////////////////////////////////////////////
module mpu_host_if (
	input  logic                clock,
	input  logic                reset,
	input  logic                host_req,
	input  mpu_pkg::host_cmd_t  host_cmd,
	output logic                host_ack,
	output mpu_pkg::host_rsp_t  host_rsp,
	output logic                map_def_req,
	input  logic                map_def_done,
	input  logic                map_def_ok,
	input  mpu_pkg::t_address_t map_def_base,
	input  mpu_pkg::map_entry_t map_entry,
	output mpu_pkg::id_t        map_query_id,
	output logic                mem_we,
	output mpu_pkg::t_address_t mem_waddr,
	output mpu_pkg::instr_t     mem_wdata,
	output logic                issue_req,
	input  logic                issue_done,
	output logic                busy
);
	import mpu_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_define,
		st_write,
		st_query,
		st_issue,
		st_ack_wait
	} state_t;

	state_t     state;
	logic       cur_valid;                  // Thread open for writes
	t_address_t cur_base;
	length_t    cur_len;
	length_t    cur_cnt;                    // Words written so far
	logic       write_ok;

	assign write_ok     = cur_valid && (cur_cnt < cur_len);
	assign host_ack     = (state == st_ack_wait);
	assign map_query_id = host_cmd.thread_id;
	assign map_def_req  = (state == st_define);
	assign issue_req    = (state == st_issue);
	assign mem_we       = (state == st_write);
	assign mem_waddr    = cur_base + cur_cnt[5:0];  // Write pointer
	assign mem_wdata    = host_cmd.instr;
	assign busy         = (state != st_idle);

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= st_idle;
			host_rsp  <= '0;
			cur_valid <= 1'b0;
			cur_base  <= '0;
			cur_len   <= '0;
			cur_cnt   <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (host_req) begin
						host_rsp.ok <= 1'b0;
						case (host_cmd.op)
							op_define: state <= st_define;
							op_write:  state <= write_ok ? st_write : st_ack_wait;
							op_run:    state <= st_query;
							default:   state <= st_ack_wait;  // Unknown op refused
						endcase
					end
				end
				st_define: begin
					if (map_def_done) begin
						host_rsp.ok <= map_def_ok;
						cur_valid   <= map_def_ok;
						cur_base    <= map_def_base;
						cur_len     <= host_cmd.length;
						cur_cnt     <= '0;
						state       <= st_ack_wait;
					end
				end
				st_write: begin
					cur_cnt     <= cur_cnt + 7'd1;
					host_rsp.ok <= 1'b1;
					state       <= st_ack_wait;
				end
				st_query: begin
					// Undefined thread is answered without an issue
					state <= map_entry.valid ? st_issue : st_ack_wait;
				end
				st_issue: begin
					if (issue_done) begin
						host_rsp.ok <= 1'b1;
						state       <= st_ack_wait;
					end
				end
				st_ack_wait: begin
					if (!host_req) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Command is held by the host until the acknowledgement
	assert property (@(posedge clock) disable iff (reset)
		host_req && !host_ack |=> !(host_req && !host_ack) || $stable(host_cmd))
		else $error("host_cmd changed while a request was pending");

endmodule

// File: common/mpu_pkg.sv
////////////////////////////////////////////////////////////
// MPU shared definitions
// Widths, host command encodings, stream beat and status
////////////////////////////////////////////////////////////
package mpu_pkg;

	// Parameter defaults, set again at the top level
	localparam int SIZE_THREAD_MEM_DEF = 64;
	localparam int NUM_ISSUE_DEF       = 4;
	localparam int NUM_THREADS         = 8;

	typedef logic [31:0] instr_t;
	typedef logic [2:0]  id_t;           // Eight threads
	typedef logic [5:0]  t_address_t;
	typedef logic [6:0]  length_t;       // 1 to 64 words
	typedef logic [2:0]  issue_no_t;     // Wraps at 8

	typedef enum logic [1:0] {
		op_define = 2'd0,
		op_write  = 2'd1,
		op_run    = 2'd2
	} host_op_t;

	typedef struct packed {
		host_op_t op;
		id_t      thread_id;
		length_t  length;                // Used by define
		instr_t   instr;                 // Used by write
	} host_cmd_t;

	typedef struct packed {
		logic ok;
	} host_rsp_t;

	typedef struct packed {
		logic       valid;
		t_address_t base;
		length_t    length;
	} map_entry_t;

	typedef struct packed {
		instr_t    instr;
		issue_no_t issue_no;
		logic      last;                 // Final word of the thread
	} tpu_beat_t;

	typedef struct packed {
		logic busy;
		logic mem_full;
		logic map_full;
		logic commit_full;
		logic sending;
	} mpu_stat_t;

endpackage
